// File: disp_defs.svh
`ifndef DISP_DEFS_SVH
`define DISP_DEFS_SVH

`define DISP_OP_W         16
`define DISP_DATA_W       16
`define DISP_REG_W        3
`define DISP_QUEUE_DEPTH  4

// opcode values
`define DISP_OP_NOP   3'd0
`define DISP_OP_ADD   3'd1
`define DISP_OP_SUB   3'd2
`define DISP_OP_AND   3'd3
`define DISP_OP_XOR   3'd4
`define DISP_OP_ADDI  3'd5
`define DISP_OP_LD    3'd6

// operation word fields
`define DISP_OPC_MSB  15
`define DISP_OPC_LSB  13
`define DISP_RD_MSB   12
`define DISP_RD_LSB   10
`define DISP_RS1_MSB  9
`define DISP_RS1_LSB  7
`define DISP_RS2_MSB  6
`define DISP_RS2_LSB  4
`define DISP_IMM_MSB  3
`define DISP_IMM_LSB  0

`endif

// File: disp_pkg.sv
`include "disp_defs.svh"

package disp_pkg;

    typedef logic [`DISP_OP_W-1:0] op_word_t;

    typedef logic [`DISP_DATA_W-1:0] data_t;

    typedef logic [`DISP_REG_W-1:0] reg_addr_t;

    typedef logic [`DISP_OPC_MSB-`DISP_OPC_LSB:0] opcode_t;

    // receiving side of the four-phase handshake
    typedef enum logic {
        IDLE,
        WAIT_DROP
    } intake_state_t;

endpackage

// File: op_intake.sv
module op_intake (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               op_req_i,
    input  disp_pkg::op_word_t op_i,
    input  logic               queue_full_i,
    output logic               op_ack_o,
    output logic               push_o,
    output disp_pkg::op_word_t push_op_o
);

    disp_pkg::intake_state_t state_q;
    disp_pkg::intake_state_t state_d;

    // accept only with room in the queue
    assign push_o    = (state_q == disp_pkg::IDLE) && op_req_i && !queue_full_i;
    assign push_op_o = op_i;

    // ack held until the sender drops req
    assign op_ack_o = (state_q == disp_pkg::WAIT_DROP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            disp_pkg::IDLE: begin
                if (push_o) begin
                    state_d = disp_pkg::WAIT_DROP;
                end
            end
            disp_pkg::WAIT_DROP: begin
                if (!op_req_i) begin
                    state_d = disp_pkg::IDLE;
                end
            end
            default: begin
                state_d = disp_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= disp_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: op_queue.sv
`include "disp_defs.svh"

module op_queue (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               push_i,
    input  disp_pkg::op_word_t push_op_i,
    input  logic [1:0]         pop_count_i,
    output logic               full_o,
    output logic               head0_valid_o,
    output disp_pkg::op_word_t head0_op_o,
    output logic               head1_valid_o,
    output disp_pkg::op_word_t head1_op_o
);

    localparam int DEPTH = `DISP_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    disp_pkg::op_word_t mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr_nx;
    logic [CNT_W-1:0]   count;

    assign rd_ptr_nx = rd_ptr + PTR_W'(1);

    assign full_o        = (count == CNT_W'(DEPTH));
    assign head0_valid_o = (count != '0);
    assign head0_op_o    = mem[rd_ptr];
    // second oldest entry, wraps with the pointer
    assign head1_valid_o = (count > CNT_W'(1));
    assign head1_op_o    = mem[rd_ptr_nx];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            rd_ptr <= rd_ptr + PTR_W'(pop_count_i);
            count  <= count + CNT_W'(push_i) - CNT_W'(pop_count_i);
        end
    end

endmodule

// File: reg_file.sv
`include "disp_defs.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_i,
    input  disp_pkg::reg_addr_t rd_addr0_i,
    input  disp_pkg::reg_addr_t rd_addr1_i,
    input  disp_pkg::reg_addr_t rd_addr2_i,
    input  disp_pkg::reg_addr_t rd_addr3_i,
    output disp_pkg::data_t     rd_data0_o,
    output disp_pkg::data_t     rd_data1_o,
    output disp_pkg::data_t     rd_data2_o,
    output disp_pkg::data_t     rd_data3_o,
    input  logic                wr_en0_i,
    input  disp_pkg::reg_addr_t wr_addr0_i,
    input  disp_pkg::data_t     wr_data0_i,
    input  logic                wr_en1_i,
    input  disp_pkg::reg_addr_t wr_addr1_i,
    input  disp_pkg::data_t     wr_data1_i
);

    localparam int NUM_REGS = 2 ** `DISP_REG_W;

    disp_pkg::data_t regs [NUM_REGS];

    // r0 reads as zero
    assign rd_data0_o = (rd_addr0_i == '0) ? '0 : regs[rd_addr0_i];
    assign rd_data1_o = (rd_addr1_i == '0) ? '0 : regs[rd_addr1_i];
    assign rd_data2_o = (rd_addr2_i == '0) ? '0 : regs[rd_addr2_i];
    assign rd_data3_o = (rd_addr3_i == '0) ? '0 : regs[rd_addr3_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en0_i) begin
                regs[wr_addr0_i] <= wr_data0_i;
            end
            // port 1 is the younger lane
            if (wr_en1_i) begin
                regs[wr_addr1_i] <= wr_data1_i;
            end
        end
    end

endmodule

// File: dispatch_stage.sv
`include "disp_defs.svh"

module dispatch_stage (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      head0_valid_i,
    input  disp_pkg::op_word_t        head0_op_i,
    input  logic                      head1_valid_i,
    input  disp_pkg::op_word_t        head1_op_i,
    output logic [1:0]                pop_count_o,
    output disp_pkg::reg_addr_t       rf_addr0_o,
    output disp_pkg::reg_addr_t       rf_addr1_o,
    output disp_pkg::reg_addr_t       rf_addr2_o,
    output disp_pkg::reg_addr_t       rf_addr3_o,
    input  disp_pkg::data_t           rf_data0_i,
    input  disp_pkg::data_t           rf_data1_i,
    input  disp_pkg::data_t           rf_data2_i,
    input  disp_pkg::data_t           rf_data3_i,
    input  logic [1:0]                ex_valid_i,
    input  disp_pkg::reg_addr_t [1:0] ex_rd_i,
    input  disp_pkg::data_t [1:0]     ex_result_i,
    input  logic                      ex_is_load_i,
    input  logic [1:0]                wb_fwd_en_i,
    input  disp_pkg::reg_addr_t [1:0] wb_fwd_rd_i,
    input  disp_pkg::data_t [1:0]     wb_fwd_data_i,
    output logic [1:0]                iss_valid_o,
    output disp_pkg::opcode_t [1:0]   iss_opcode_o,
    output disp_pkg::reg_addr_t [1:0] iss_rd_o,
    output logic [1:0]                iss_we_o,
    output disp_pkg::data_t [1:0]     iss_a_o,
    output disp_pkg::data_t [1:0]     iss_b_o,
    output logic [1:0][`DISP_IMM_MSB:`DISP_IMM_LSB] iss_imm_o
);

    localparam int IMM_W = `DISP_IMM_MSB - `DISP_IMM_LSB + 1;

    // every defined opcode except NOP reads rs1 and writes rd
    function automatic logic is_real_op(disp_pkg::opcode_t opc);
        return (opc >= `DISP_OP_ADD) && (opc <= `DISP_OP_LD);
    endfunction

    function automatic logic reads_rs2(disp_pkg::opcode_t opc);
        return (opc >= `DISP_OP_ADD) && (opc <= `DISP_OP_XOR);
    endfunction

    disp_pkg::op_word_t  op [2];
    disp_pkg::opcode_t   opc [2];
    disp_pkg::reg_addr_t rd [2];
    disp_pkg::reg_addr_t rs1 [2];
    disp_pkg::reg_addr_t rs2 [2];
    logic [IMM_W-1:0]    imm [2];
    disp_pkg::data_t     b_val [2];
    logic [1:0]          we;
    logic [1:0]          load_use;
    logic                raw;
    logic                issue0;
    logic                issue_pair;
    disp_pkg::reg_addr_t src [4];
    disp_pkg::data_t     rf_val [4];
    disp_pkg::data_t     opnd [4];

    assign op[0] = head0_op_i;
    assign op[1] = head1_op_i;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            opc[i] = op[i][`DISP_OPC_MSB:`DISP_OPC_LSB];
            rd[i]  = op[i][`DISP_RD_MSB:`DISP_RD_LSB];
            rs1[i] = op[i][`DISP_RS1_MSB:`DISP_RS1_LSB];
            rs2[i] = op[i][`DISP_RS2_MSB:`DISP_RS2_LSB];
            imm[i] = op[i][`DISP_IMM_MSB:`DISP_IMM_LSB];
            we[i]  = is_real_op(opc[i]) && (rd[i] != '0);
            // load in execute feeding this op
            load_use[i] = ex_is_load_i &&
                          ((is_real_op(opc[i]) && (rs1[i] == ex_rd_i[0])) ||
                           (reads_rs2(opc[i]) && (rs2[i] == ex_rd_i[0])));
        end
    end

    assign raw = we[0] &&
                 ((is_real_op(opc[1]) && (rs1[1] == rd[0])) ||
                  (reads_rs2(opc[1]) && (rs2[1] == rd[0])));

    assign issue0     = head0_valid_i && !load_use[0];
    assign issue_pair = issue0 && head1_valid_i && !raw && !load_use[1] &&
                        (opc[0] != `DISP_OP_LD) && (opc[1] != `DISP_OP_LD);

    assign pop_count_o = issue_pair ? 2'd2 : {1'b0, issue0};

    assign src[0]     = rs1[0];
    assign src[1]     = rs2[0];
    assign src[2]     = rs1[1];
    assign src[3]     = rs2[1];
    assign rf_addr0_o = src[0];
    assign rf_addr1_o = src[1];
    assign rf_addr2_o = src[2];
    assign rf_addr3_o = src[3];
    assign rf_val[0]  = rf_data0_i;
    assign rf_val[1]  = rf_data1_i;
    assign rf_val[2]  = rf_data2_i;
    assign rf_val[3]  = rf_data3_i;

    // youngest producer first
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (src[k] == '0) begin
                opnd[k] = '0;
            end else if (ex_valid_i[1] && (ex_rd_i[1] == src[k])) begin
                opnd[k] = ex_result_i[1];
            end else if (ex_valid_i[0] && !ex_is_load_i && (ex_rd_i[0] == src[k])) begin
                opnd[k] = ex_result_i[0];
            end else if (wb_fwd_en_i[1] && (wb_fwd_rd_i[1] == src[k])) begin
                opnd[k] = wb_fwd_data_i[1];
            end else if (wb_fwd_en_i[0] && (wb_fwd_rd_i[0] == src[k])) begin
                opnd[k] = wb_fwd_data_i[0];
            end else begin
                opnd[k] = rf_val[k];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (opc[i] == `DISP_OP_ADDI || opc[i] == `DISP_OP_LD) begin
                b_val[i] = disp_pkg::data_t'(imm[i]);
            end else begin
                b_val[i] = opnd[2*i+1];
            end
        end
    end

    // a stalled head leaves a bubble
    always_ff @(posedge clk) begin
        if (rst_i) begin
            iss_valid_o <= '0;
            iss_we_o    <= '0;
        end else begin
            iss_valid_o <= {issue_pair, issue0};
            iss_we_o    <= {issue_pair && we[1], issue0 && we[0]};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            iss_opcode_o[i] <= opc[i];
            iss_rd_o[i]     <= rd[i];
            iss_a_o[i]      <= opnd[2*i];
            iss_b_o[i]      <= b_val[i];
            iss_imm_o[i]    <= imm[i];
        end
    end

endmodule

// File: exec_stage.sv
`include "disp_defs.svh"

module exec_stage (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [1:0]                iss_valid_i,
    input  disp_pkg::opcode_t [1:0]   iss_opcode_i,
    input  disp_pkg::reg_addr_t [1:0] iss_rd_i,
    input  logic [1:0]                iss_we_i,
    input  disp_pkg::data_t [1:0]     iss_a_i,
    input  disp_pkg::data_t [1:0]     iss_b_i,
    input  logic [1:0][`DISP_IMM_MSB:`DISP_IMM_LSB] iss_imm_i,
    output logic [1:0]                ex_valid_o,
    output disp_pkg::reg_addr_t [1:0] ex_rd_o,
    output disp_pkg::data_t [1:0]     ex_result_o,
    output logic                      ex_is_load_o,
    output disp_pkg::data_t           mem_addr_o,
    input  disp_pkg::data_t           mem_rdata_i,
    output logic [1:0]                wb_valid_o,
    output disp_pkg::reg_addr_t [1:0] wb_rd_o,
    output disp_pkg::data_t [1:0]     wb_data_o,
    output logic                      rf_wr_en0_o,
    output disp_pkg::reg_addr_t       rf_wr_addr0_o,
    output disp_pkg::data_t           rf_wr_data0_o,
    output logic                      rf_wr_en1_o,
    output disp_pkg::reg_addr_t       rf_wr_addr1_o,
    output disp_pkg::data_t           rf_wr_data1_o
);

    disp_pkg::data_t [1:0] result;

    // loads only ever issue on lane 0
    assign mem_addr_o   = iss_a_i[0] + disp_pkg::data_t'(iss_imm_i[0]);
    assign ex_is_load_o = ex_valid_o[0] && (iss_opcode_i[0] == `DISP_OP_LD);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (iss_opcode_i[i])
                `DISP_OP_ADD:  result[i] = iss_a_i[i] + iss_b_i[i];
                `DISP_OP_ADDI: result[i] = iss_a_i[i] + iss_b_i[i];
                `DISP_OP_SUB:  result[i] = iss_a_i[i] - iss_b_i[i];
                `DISP_OP_AND:  result[i] = iss_a_i[i] & iss_b_i[i];
                `DISP_OP_XOR:  result[i] = iss_a_i[i] ^ iss_b_i[i];
                `DISP_OP_LD:   result[i] = mem_rdata_i;
                default:       result[i] = '0;
            endcase
        end
    end

    assign ex_valid_o  = iss_valid_i & iss_we_i;
    assign ex_rd_o     = iss_rd_i;
    assign ex_result_o = result;

    // writeback register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= '0;
        end else begin
            wb_valid_o <= ex_valid_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= iss_rd_i;
        wb_data_o <= result;
    end

    assign rf_wr_en0_o   = wb_valid_o[0];
    assign rf_wr_addr0_o = wb_rd_o[0];
    assign rf_wr_data0_o = wb_data_o[0];
    assign rf_wr_en1_o   = wb_valid_o[1];
    assign rf_wr_addr1_o = wb_rd_o[1];
    assign rf_wr_data1_o = wb_data_o[1];

endmodule

// File: disp_top.sv
module disp_top (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      op_req_i,
    input  disp_pkg::op_word_t        op_i,
    output logic                      op_ack_o,
    output disp_pkg::data_t           mem_addr_o,
    input  disp_pkg::data_t           mem_rdata_i,
    output logic [1:0]                wb_valid_o,
    output disp_pkg::reg_addr_t [1:0] wb_rd_o,
    output disp_pkg::data_t [1:0]     wb_data_o
);

    logic                      push;
    disp_pkg::op_word_t        push_op;
    logic                      queue_full;
    logic                      head0_valid;
    disp_pkg::op_word_t        head0_op;
    logic                      head1_valid;
    disp_pkg::op_word_t        head1_op;
    logic [1:0]                pop_count;
    disp_pkg::reg_addr_t       rf_addr0;
    disp_pkg::reg_addr_t       rf_addr1;
    disp_pkg::reg_addr_t       rf_addr2;
    disp_pkg::reg_addr_t       rf_addr3;
    disp_pkg::data_t           rf_data0;
    disp_pkg::data_t           rf_data1;
    disp_pkg::data_t           rf_data2;
    disp_pkg::data_t           rf_data3;
    logic [1:0]                ex_valid;
    disp_pkg::reg_addr_t [1:0] ex_rd;
    disp_pkg::data_t [1:0]     ex_result;
    logic                      ex_is_load;
    logic [1:0]                iss_valid;
    disp_pkg::opcode_t [1:0]   iss_opcode;
    disp_pkg::reg_addr_t [1:0] iss_rd;
    logic [1:0]                iss_we;
    disp_pkg::data_t [1:0]     iss_a;
    disp_pkg::data_t [1:0]     iss_b;
    logic [1:0][3:0]           iss_imm;
    logic                      rf_wr_en0;
    disp_pkg::reg_addr_t       rf_wr_addr0;
    disp_pkg::data_t           rf_wr_data0;
    logic                      rf_wr_en1;
    disp_pkg::reg_addr_t       rf_wr_addr1;
    disp_pkg::data_t           rf_wr_data1;

    op_intake i_intake (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_req_i     (op_req_i),
        .op_i         (op_i),
        .queue_full_i (queue_full),
        .op_ack_o     (op_ack_o),
        .push_o       (push),
        .push_op_o    (push_op)
    );

    op_queue i_queue (
        .clk           (clk),
        .rst_i         (rst_i),
        .push_i        (push),
        .push_op_i     (push_op),
        .pop_count_i   (pop_count),
        .full_o        (queue_full),
        .head0_valid_o (head0_valid),
        .head0_op_o    (head0_op),
        .head1_valid_o (head1_valid),
        .head1_op_o    (head1_op)
    );

    // writeback register doubles as the second forward source
    dispatch_stage i_dispatch (
        .clk           (clk),
        .rst_i         (rst_i),
        .head0_valid_i (head0_valid),
        .head0_op_i    (head0_op),
        .head1_valid_i (head1_valid),
        .head1_op_i    (head1_op),
        .pop_count_o   (pop_count),
        .rf_addr0_o    (rf_addr0),
        .rf_addr1_o    (rf_addr1),
        .rf_addr2_o    (rf_addr2),
        .rf_addr3_o    (rf_addr3),
        .rf_data0_i    (rf_data0),
        .rf_data1_i    (rf_data1),
        .rf_data2_i    (rf_data2),
        .rf_data3_i    (rf_data3),
        .ex_valid_i    (ex_valid),
        .ex_rd_i       (ex_rd),
        .ex_result_i   (ex_result),
        .ex_is_load_i  (ex_is_load),
        .wb_fwd_en_i   (wb_valid_o),
        .wb_fwd_rd_i   (wb_rd_o),
        .wb_fwd_data_i (wb_data_o),
        .iss_valid_o   (iss_valid),
        .iss_opcode_o  (iss_opcode),
        .iss_rd_o      (iss_rd),
        .iss_we_o      (iss_we),
        .iss_a_o       (iss_a),
        .iss_b_o       (iss_b),
        .iss_imm_o     (iss_imm)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rd_addr0_i (rf_addr0),
        .rd_addr1_i (rf_addr1),
        .rd_addr2_i (rf_addr2),
        .rd_addr3_i (rf_addr3),
        .rd_data0_o (rf_data0),
        .rd_data1_o (rf_data1),
        .rd_data2_o (rf_data2),
        .rd_data3_o (rf_data3),
        .wr_en0_i   (rf_wr_en0),
        .wr_addr0_i (rf_wr_addr0),
        .wr_data0_i (rf_wr_data0),
        .wr_en1_i   (rf_wr_en1),
        .wr_addr1_i (rf_wr_addr1),
        .wr_data1_i (rf_wr_data1)
    );

    exec_stage i_exec (
        .clk           (clk),
        .rst_i         (rst_i),
        .iss_valid_i   (iss_valid),
        .iss_opcode_i  (iss_opcode),
        .iss_rd_i      (iss_rd),
        .iss_we_i      (iss_we),
        .iss_a_i       (iss_a),
        .iss_b_i       (iss_b),
        .iss_imm_i     (iss_imm),
        .ex_valid_o    (ex_valid),
        .ex_rd_o       (ex_rd),
        .ex_result_o   (ex_result),
        .ex_is_load_o  (ex_is_load),
        .mem_addr_o    (mem_addr_o),
        .mem_rdata_i   (mem_rdata_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .rf_wr_en0_o   (rf_wr_en0),
        .rf_wr_addr0_o (rf_wr_addr0),
        .rf_wr_data0_o (rf_wr_data0),
        .rf_wr_en1_o   (rf_wr_en1),
        .rf_wr_addr1_o (rf_wr_addr1),
        .rf_wr_data1_o (rf_wr_data1)
    );

endmodule

// File: disp_asserts.sv
`include "disp_defs.svh"

module disp_handshake_asserts (
    input logic                                 clk,
    input logic                                 rst_i,
    input logic                                 req_i,
    input logic                                 ack_i,
    input logic                                 push_i,
    input logic                                 full_i,
    input logic [1:0]                           pop_count_i,
    input logic [$clog2(`DISP_QUEUE_DEPTH):0]   occupancy_i
);

    localparam int OCC_W = $clog2(`DISP_QUEUE_DEPTH) + 1;

    int fail_count = 0;

    // ack answers a request seen in the accepting cycle
    ack_after_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
    else begin
        fail_count++;
        $error("ack rose without a pending request");
    end

    ack_low_after_reset: assert property (@(posedge clk) rst_i |=> !ack_i)
    else begin
        fail_count++;
        $error("ack high in the cycle after reset");
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst_i)
        !(push_i && full_i))
    else begin
        fail_count++;
        $error("push while the queue is full");
    end

    pop_within_occupancy: assert property (@(posedge clk) disable iff (rst_i)
        OCC_W'(pop_count_i) <= occupancy_i)
    else begin
        fail_count++;
        $error("pop count above queue occupancy");
    end

endmodule

// intake side sees no pops
bind op_intake disp_handshake_asserts i_hs_asserts (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (op_req_i),
    .ack_i       (op_ack_o),
    .push_i      (push_o),
    .full_i      (queue_full_i),
    .pop_count_i (2'd0),
    .occupancy_i ('0)
);

// queue side has no handshake
bind op_queue disp_handshake_asserts i_hs_asserts (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (1'b0),
    .ack_i       (1'b0),
    .push_i      (push_i),
    .full_i      (full_o),
    .pop_count_i (pop_count_i),
    .occupancy_i (count)
);

// File: tb_disp.sv
`include "disp_defs.svh"

module tb_disp;

    localparam int NUM_OPS     = 34;
    localparam int CYCLE_LIMIT = 8 * NUM_OPS + 200;
    // writeback register loads two edges after the accept edge
    localparam int WB_LATENCY  = 2;

    logic                      clk;
    logic                      rst;
    logic                      op_req;
    disp_pkg::op_word_t        op;
    logic                      op_ack;
    disp_pkg::data_t           mem_addr;
    disp_pkg::data_t           mem_rdata;
    logic [1:0]                wb_valid;
    disp_pkg::reg_addr_t [1:0] wb_rd;
    disp_pkg::data_t [1:0]     wb_data;

    integer seed;
    int     cyc = 0;
    int     errors = 0;
    int     err_start;
    int     tests_ok = 0;
    int     tests_bad = 0;
    int     ack_count = 0;
    logic   ack_prev = 1'b0;
    bit     latency_on = 1'b0;
    string  cur_test = "reset";

    disp_pkg::data_t     model_regs [2 ** `DISP_REG_W];
    disp_pkg::reg_addr_t exp_rd [$];
    disp_pkg::data_t     exp_data [$];
    disp_pkg::op_word_t  exp_op [$];
    int                  exp_cyc [$];

    disp_top i_dut (
        .clk         (clk),
        .rst_i       (rst),
        .op_req_i    (op_req),
        .op_i        (op),
        .op_ack_o    (op_ack),
        .mem_addr_o  (mem_addr),
        .mem_rdata_i (mem_rdata),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    function automatic disp_pkg::data_t mem_read(disp_pkg::data_t addr);
        return addr ^ 16'h5A5A;
    endfunction

    assign mem_rdata = mem_read(mem_addr);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("timeout: operations still outstanding after %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    function automatic disp_pkg::op_word_t make_op(disp_pkg::opcode_t opc,
            disp_pkg::reg_addr_t rd, disp_pkg::reg_addr_t rs1,
            disp_pkg::reg_addr_t rs2, logic [3:0] imm);
        return {opc, rd, rs1, rs2, imm};
    endfunction

    // source fields per opcode class
    function automatic bit reads_reg(disp_pkg::op_word_t w, disp_pkg::reg_addr_t r);
        disp_pkg::opcode_t opc;
        opc = w[`DISP_OPC_MSB:`DISP_OPC_LSB];
        case (opc)
            `DISP_OP_ADD, `DISP_OP_SUB, `DISP_OP_AND, `DISP_OP_XOR:
                return (w[`DISP_RS1_MSB:`DISP_RS1_LSB] == r) ||
                       (w[`DISP_RS2_MSB:`DISP_RS2_LSB] == r);
            `DISP_OP_ADDI, `DISP_OP_LD:
                return w[`DISP_RS1_MSB:`DISP_RS1_LSB] == r;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic bit is_raw(disp_pkg::op_word_t older, disp_pkg::op_word_t younger);
        disp_pkg::reg_addr_t rd;
        rd = older[`DISP_RD_MSB:`DISP_RD_LSB];
        return (rd != '0) && reads_reg(younger, rd);
    endfunction

    task automatic check_addr(input string what, input disp_pkg::reg_addr_t exp_v,
                              input disp_pkg::reg_addr_t act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_data(input string what, input disp_pkg::data_t exp_v,
                              input disp_pkg::data_t act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < 2 ** `DISP_REG_W; i++) begin
            model_regs[i] = '0;
        end
    endtask

    // queues a retire for every nonzero rd in program order
    task automatic model_exec(input disp_pkg::op_word_t w, input int acc_cyc);
        disp_pkg::opcode_t   opc;
        disp_pkg::reg_addr_t rd;
        disp_pkg::data_t     a;
        disp_pkg::data_t     b;
        disp_pkg::data_t     imm;
        disp_pkg::data_t     res;
        bit                  writes;
        opc    = w[`DISP_OPC_MSB:`DISP_OPC_LSB];
        rd     = w[`DISP_RD_MSB:`DISP_RD_LSB];
        a      = model_regs[w[`DISP_RS1_MSB:`DISP_RS1_LSB]];
        b      = model_regs[w[`DISP_RS2_MSB:`DISP_RS2_LSB]];
        imm    = disp_pkg::data_t'(w[`DISP_IMM_MSB:`DISP_IMM_LSB]);
        writes = 1'b1;
        res    = '0;
        case (opc)
            `DISP_OP_ADD:  res = a + b;
            `DISP_OP_SUB:  res = a - b;
            `DISP_OP_AND:  res = a & b;
            `DISP_OP_XOR:  res = a ^ b;
            `DISP_OP_ADDI: res = a + imm;
            `DISP_OP_LD:   res = mem_read(a + imm);
            default:       writes = 1'b0;
        endcase
        if (writes && rd != '0) begin
            model_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
            exp_op.push_back(w);
            exp_cyc.push_back(acc_cyc);
        end
    endtask

    // full four-phase exchange from 1 unit after an edge
    task automatic send_op(input disp_pkg::op_word_t w);
        op     = w;
        op_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!op_ack);
        model_exec(w, cyc);
        op_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (op_ack);
    endtask

    task automatic retire_one(input int lane);
        disp_pkg::reg_addr_t rd;
        disp_pkg::data_t     data;
        int                  acc_cyc;
        disp_pkg::op_word_t  w;
        if (exp_rd.size() == 0) begin
            $display("error in %s: lane %0d retired r%0d with nothing outstanding",
                     cur_test, lane, wb_rd[lane]);
            errors++;
        end else begin
            rd      = exp_rd.pop_front();
            data    = exp_data.pop_front();
            acc_cyc = exp_cyc.pop_front();
            w       = exp_op.pop_front();
            check_addr($sformatf("lane %0d rd", lane), rd, wb_rd[lane]);
            check_data($sformatf("lane %0d data", lane), data, wb_data[lane]);
            if (latency_on) begin
                check_count($sformatf("latency of %h", w), WB_LATENCY, cyc - acc_cyc);
            end
        end
    endtask

    // lane 0 retires first as the older op
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_valid == 2'b11 && exp_op.size() >= 2) begin
                if (is_raw(exp_op[0], exp_op[1])) begin
                    $display("error in %s: dependent operations retired in one cycle", cur_test);
                    errors++;
                end
            end
            for (int lane = 0; lane < 2; lane++) begin
                if (wb_valid[lane]) begin
                    retire_one(lane);
                end
            end
            if (op_ack && !ack_prev) begin
                ack_count++;
            end
            ack_prev = op_ack;
        end
    end

    task automatic wait_retired();
        while (exp_rd.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = errors;
    endtask

    task automatic report_test();
        if (errors == err_start) begin
            $display("%s: ok", cur_test);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", cur_test, errors - err_start);
            tests_bad++;
        end
    endtask

    task automatic independent_pair();
        begin_test("independent_pair");
        latency_on = 1'b1;
        send_op(make_op(`DISP_OP_ADDI, 3'd1, 3'd0, 3'd0, 4'd5));
        send_op(make_op(`DISP_OP_ADDI, 3'd2, 3'd0, 3'd0, 4'd9));
        send_op(make_op(`DISP_OP_ADD, 3'd3, 3'd1, 3'd2, 4'd0));
        send_op(make_op(`DISP_OP_XOR, 3'd4, 3'd1, 3'd2, 4'd0));
        wait_retired();
        latency_on = 1'b0;
        report_test();
    endtask

    task automatic dependent_chain();
        begin_test("dependent_chain");
        send_op(make_op(`DISP_OP_ADDI, 3'd1, 3'd1, 3'd0, 4'd7));
        send_op(make_op(`DISP_OP_ADD, 3'd2, 3'd1, 3'd1, 4'd0));
        send_op(make_op(`DISP_OP_SUB, 3'd3, 3'd2, 3'd1, 4'd0));
        send_op(make_op(`DISP_OP_SUB, 3'd4, 3'd3, 3'd2, 4'd0));
        send_op(make_op(`DISP_OP_SUB, 3'd5, 3'd4, 3'd3, 4'd0));
        send_op(make_op(`DISP_OP_AND, 3'd6, 3'd5, 3'd2, 4'd0));
        wait_retired();
        report_test();
    endtask

    task automatic load_use();
        begin_test("load_use");
        send_op(make_op(`DISP_OP_ADDI, 3'd2, 3'd0, 3'd0, 4'd12));
        send_op(make_op(`DISP_OP_LD, 3'd3, 3'd2, 3'd0, 4'd3));
        send_op(make_op(`DISP_OP_ADD, 3'd4, 3'd3, 3'd1, 4'd0));
        send_op(make_op(`DISP_OP_LD, 3'd5, 3'd4, 3'd0, 4'd1));
        send_op(make_op(`DISP_OP_XOR, 3'd6, 3'd5, 3'd3, 4'd0));
        wait_retired();
        report_test();
    endtask

    task automatic back_pressure();
        int                  ack_start;
        disp_pkg::opcode_t   opc;
        disp_pkg::reg_addr_t rd;
        disp_pkg::reg_addr_t rs1;
        disp_pkg::reg_addr_t rs2;
        logic [3:0]          imm;
        disp_pkg::op_word_t  w;
        begin_test("back_pressure");
        ack_start = ack_count;
        for (int n = 0; n < 12; n++) begin
            case ($unsigned($random(seed)) % 5)
                0:       opc = `DISP_OP_ADD;
                1:       opc = `DISP_OP_SUB;
                2:       opc = `DISP_OP_AND;
                3:       opc = `DISP_OP_XOR;
                default: opc = `DISP_OP_ADDI;
            endcase
            rd  = disp_pkg::reg_addr_t'($random(seed));
            rs1 = disp_pkg::reg_addr_t'($random(seed));
            rs2 = disp_pkg::reg_addr_t'($random(seed));
            imm = 4'($random(seed));
            w   = make_op(opc, rd, rs1, rs2, imm);
            send_op(w);
        end
        wait_retired();
        check_count("acknowledges", 12, ack_count - ack_start);
        report_test();
    endtask

    task automatic zero_reg_and_same_dest();
        begin_test("zero_reg_and_same_dest");
        send_op(make_op(`DISP_OP_ADDI, 3'd0, 3'd1, 3'd0, 4'd3));
        send_op(make_op(`DISP_OP_ADD, 3'd7, 3'd0, 3'd0, 4'd0));
        send_op(make_op(`DISP_OP_ADDI, 3'd5, 3'd0, 3'd0, 4'd4));
        send_op(make_op(`DISP_OP_ADDI, 3'd5, 3'd0, 3'd0, 4'd11));
        send_op(make_op(`DISP_OP_ADD, 3'd6, 3'd5, 3'd0, 4'd0));
        send_op(make_op(`DISP_OP_NOP, 3'd0, 3'd0, 3'd0, 4'd0));
        send_op(make_op(`DISP_OP_XOR, 3'd0, 3'd5, 3'd5, 4'd0));
        wait_retired();
        report_test();
    endtask

    initial begin
        int assert_fails;
        seed   = 52196;
        rst    = 1'b1;
        op_req = 1'b0;
        op     = '0;
        clear_model();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        independent_pair();
        dependent_chain();
        load_use();
        back_pressure();
        zero_reg_and_same_dest();

        assert_fails = i_dut.i_intake.i_hs_asserts.fail_count +
                       i_dut.i_queue.i_hs_asserts.fail_count;
        errors += assert_fails;
        $display("tests ok %0d, tests with errors %0d, assertion failures %0d",
                 tests_ok, tests_bad, assert_fails);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
disp_pkg.sv
op_intake.sv
op_queue.sv
reg_file.sv
dispatch_stage.sv
exec_stage.sv
disp_top.sv
disp_asserts.sv
tb_disp.sv
